// File: rtl/cart_pkg.sv
package cart_pkg;

   // SRAM geometry of 16-bit words with two byte lanes
   localparam int SRAM_AW = 20;
   localparam int SRAM_DW = 16;
   localparam int BYTE_AW = SRAM_AW + 1;

   // Console bus width and strobe synchronizer depth
   localparam int SNES_AW    = 24;
   localparam int SYNC_DEPTH = 2;

   typedef enum logic {
      MAP_HIROM = 1'b0,
      MAP_LOROM = 1'b1
   } mapper_e;

   // One console address word, read through the view of the active mapper
   typedef union packed {
      struct packed {
         logic [7:0]  bank;
         logic        a15;
         logic [14:0] offs;
      } lo;
      struct packed {
         logic [7:0]  bank;
         logic [15:0] offs;
      } hi;
   } snes_addr_u;

   // Save RAM occupies the top 64 KiB of the SRAM
   localparam logic [BYTE_AW-1:0] SAVERAM_BASE = 21'h1F0000;

endpackage

// File: rtl/cmd_pkg.sv
package cmd_pkg;

   // Opcode in the high nibble of the first byte of a message
   typedef enum logic [3:0] {
      CMD_NOP           = 4'h0,
      CMD_SET_MAPPER    = 4'h1,
      CMD_SET_ADDR      = 4'h2,
      CMD_SET_ROM_MASK  = 4'h3,
      CMD_SET_SAVE_MASK = 4'h4,
      CMD_READ          = 4'h8,
      CMD_WRITE         = 4'h9
   } cmd_op_e;

   // Memory cycle slots
   // Console owns 0..4, MCU owns 5..9
   localparam logic [3:0] SLOT_MCU_FIRST = 4'd5;
   localparam logic [3:0] SLOT_LAST      = 4'd9;

endpackage

// File: rtl/bus_sync.sv
`timescale 1ns/10ps

module bus_sync import cart_pkg::*; #(
   parameter int HIST_DEPTH = 7
) (
   input  logic CLK2,
   input  logic rst_n,
   input  logic snes_rd_n,
   input  logic snes_wr_n,
   output logic rd_s,
   output logic wr_s,
   output logic cycle_start
);

   logic [SYNC_DEPTH-1:0] rd_sync;
   logic [SYNC_DEPTH-1:0] wr_sync;
   logic [HIST_DEPTH-1:0] rw_hist;
   logic                  rw_s;

   assign rd_s = rd_sync[SYNC_DEPTH-1];
   assign wr_s = wr_sync[SYNC_DEPTH-1];

   // Bus is idle while both strobes are high
   assign rw_s = rd_s & wr_s;

   always_ff @(posedge CLK2 or negedge rst_n) begin
      if (!rst_n) begin
         rd_sync     <= '1;
         wr_sync     <= '1;
         rw_hist     <= '1;
         cycle_start <= 1'b0;
      end else begin
         rd_sync     <= {rd_sync[SYNC_DEPTH-2:0], snes_rd_n};
         wr_sync     <= {wr_sync[SYNC_DEPTH-2:0], snes_wr_n};
         rw_hist     <= {rw_hist[HIST_DEPTH-2:0], rw_s};
         // Falling strobe after a full idle history
         cycle_start <= (&rw_hist) & ~rw_s;
      end
   end

endmodule

// File: rtl/slot_timer.sv
`timescale 1ns/10ps

module slot_timer import cmd_pkg::*; (
   input  logic       CLK2,
   input  logic       rst_n,
   input  logic       slot_clear,
   input  logic [3:0] slot_first,
   input  logic       slot_run,
   output logic [3:0] slot,
   output logic       slot_last
);

   assign slot_last = (slot == SLOT_LAST);

   // Parks on the last slot until the FSM starts the next cycle
   always_ff @(posedge CLK2 or negedge rst_n) begin
      if (!rst_n) begin
         slot <= SLOT_LAST;
      end else if (slot_clear) begin
         slot <= slot_first;
      end else if (slot_run && !slot_last) begin
         slot <= slot + 4'd1;
      end
   end

   // A restart value from the FSM must also stay inside the cycle
   assert property (@(posedge CLK2) disable iff (!rst_n) slot <= SLOT_LAST);

endmodule

// File: rtl/cycle_fsm.sv
`timescale 1ns/10ps

module cycle_fsm import cmd_pkg::*; (
   input  logic       CLK2,
   input  logic       rst_n,
   input  logic       cycle_start,
   input  logic       rd_s,
   input  logic       wr_s,
   input  logic       snes_cs_n,
   input  logic       mcu_req,
   input  logic       mcu_is_write,
   input  logic       save_hit,
   input  logic [3:0] slot,
   input  logic       slot_last,
   output logic       slot_clear,
   output logic [3:0] slot_first,
   output logic       slot_run,
   output logic       phase_mcu,
   output logic       sram_oe_n,
   output logic       sram_we_n,
   output logic       snes_latch,
   output logic       mcu_latch,
   output logic       snes_rd_active,
   output logic       mcu_done
);

   localparam logic [1:0] ST_IDLE    = 2'd0;
   localparam logic [1:0] ST_CONSOLE = 2'd1;
   localparam logic [1:0] ST_MCU     = 2'd2;

   // Decode runs one slot ahead of the registered SRAM strobes
   localparam logic [3:0] SLOT_CON_WR  = 4'd2;
   localparam logic [3:0] SLOT_CON_END = SLOT_MCU_FIRST - 4'd1;
   localparam logic [3:0] SLOT_MCU_END = SLOT_LAST - 4'd1;

   logic [1:0] state;
   logic       rd_cyc;
   logic       wr_cyc;
   logic       mcu_cyc;
   logic       busy;
   logic       con_win;
   logic       mcu_win;
   logic       con_rd;
   logic       con_wr;
   logic       mcu_rd;
   logic       mcu_wr;

   ////////////////////////////////////////////////////////////
   // Slot decode

   assign busy    = (state != ST_IDLE) & ~cycle_start;
   assign con_win = busy & (state == ST_CONSOLE) & (slot < SLOT_CON_END);
   assign mcu_win = busy & mcu_cyc & (slot >= SLOT_MCU_FIRST) & (slot < SLOT_MCU_END);

   assign con_rd = con_win & rd_cyc;
   assign con_wr = con_win & wr_cyc & save_hit & (slot >= SLOT_CON_WR);
   assign mcu_rd = mcu_win & ~mcu_is_write;
   assign mcu_wr = mcu_win & mcu_is_write;

   assign phase_mcu = (state == ST_MCU) | ((state == ST_CONSOLE) & (slot >= SLOT_MCU_FIRST));

   // Read data is sampled on the last slot with oe low
   assign snes_latch = busy & (state == ST_CONSOLE) & rd_cyc & (slot == SLOT_CON_END);
   assign mcu_latch  = busy & mcu_cyc & ~mcu_is_write & (slot == SLOT_MCU_END);
   assign mcu_done   = busy & mcu_cyc & slot_last;

   assign snes_rd_active = rd_cyc & ~rd_s & ~snes_cs_n;

   // A console start always wins and restarts at slot 0
   assign slot_clear = cycle_start | ((state == ST_IDLE) & mcu_req);
   assign slot_first = cycle_start ? 4'd0 : SLOT_MCU_FIRST;
   assign slot_run   = busy;

   ////////////////////////////////////////////////////////////
   // State and SRAM strobes

   always_ff @(posedge CLK2 or negedge rst_n) begin
      if (!rst_n) begin
         state     <= ST_IDLE;
         rd_cyc    <= 1'b0;
         wr_cyc    <= 1'b0;
         mcu_cyc   <= 1'b0;
         sram_oe_n <= 1'b1;
         sram_we_n <= 1'b1;
      end else begin
         sram_oe_n <= ~(con_rd | mcu_rd);
         sram_we_n <= ~(con_wr | mcu_wr);
         if (cycle_start) begin
            state   <= ST_CONSOLE;
            rd_cyc  <= ~rd_s;
            wr_cyc  <= ~wr_s;
            mcu_cyc <= 1'b0;
         end else begin
            case (state)
               ST_IDLE: begin
                  if (mcu_req) begin
                     state   <= ST_MCU;
                     mcu_cyc <= 1'b1;
                  end
               end
               default: begin
                  // MCU half of a full cycle serves whatever is pending by now
                  if (state == ST_CONSOLE && slot == SLOT_CON_END) begin
                     mcu_cyc <= mcu_req;
                  end
                  if (slot_last) begin
                     state   <= ST_IDLE;
                     mcu_cyc <= 1'b0;
                  end
               end
            endcase
         end
      end
   end

   assert property (@(posedge CLK2) disable iff (!rst_n) sram_oe_n | sram_we_n);

   // Console writes reach the SRAM only inside save RAM
   assert property (@(posedge CLK2) disable iff (!rst_n)
      (!sram_we_n && !phase_mcu) |-> save_hit);

endmodule

// File: rtl/addr_map.sv
`timescale 1ns/10ps

module addr_map import cart_pkg::*; (
   input  logic               CLK2,
   input  logic               rst_n,
   input  logic [SNES_AW-1:0] snes_addr,
   input  mapper_e            mapper,
   input  logic [BYTE_AW-1:0] rom_mask,
   input  logic [BYTE_AW-1:0] save_mask,
   input  logic [BYTE_AW-1:0] mcu_addr,
   input  logic               phase_mcu,
   output logic [SRAM_AW-1:0] sram_addr,
   output logic               lane_hi,
   output logic               save_hit,
   output logic               rom_hit
);

   snes_addr_u         a;
   logic               lo_rom;
   logic               lo_save;
   logic               hi_rom;
   logic               hi_save;
   logic               is_rom;
   logic               is_save;
   logic [BYTE_AW-1:0] rom_raw;
   logic [BYTE_AW-1:0] save_raw;
   logic [BYTE_AW-1:0] byte_addr;

   assign a = snes_addr;

   ////////////////////////////////////////////////////////////
   // Region decode for both mappers

   // LoROM has ROM in the upper half of each bank
   assign lo_rom  = a.lo.a15;
   assign lo_save = ~a.lo.a15 & (a.lo.bank >= 8'h70) & (a.lo.bank <= 8'h7D);

   assign hi_rom  = (a.hi.bank[7:6] == 2'b11) |
                    ((a.hi.bank[7:6] == 2'b01) & (a.hi.bank[5:0] <= 6'h3D));
   // Banks 20-3F and A0-BF at 6000-7FFF
   assign hi_save = (a.hi.bank[6:5] == 2'b01) & (a.hi.offs[15:13] == 3'b011);

   always_comb begin
      if (mapper == MAP_LOROM) begin
         rom_raw  = BYTE_AW'({a.lo.bank[6:0], a.lo.offs});
         save_raw = BYTE_AW'({a.lo.bank[3:0], a.lo.offs});
         is_rom   = lo_rom;
         is_save  = lo_save;
      end else begin
         rom_raw  = BYTE_AW'({a.hi.bank[5:0], a.hi.offs});
         save_raw = BYTE_AW'({a.hi.bank[4:0], a.hi.offs[12:0]});
         is_rom   = hi_rom;
         is_save  = hi_save;
      end
   end

   ////////////////////////////////////////////////////////////
   // Registered SRAM address

   always_ff @(posedge CLK2) begin
      if (phase_mcu) begin
         byte_addr <= mcu_addr;
      end else if (is_save) begin
         byte_addr <= SAVERAM_BASE + (save_raw & save_mask);
      end else begin
         byte_addr <= rom_raw & rom_mask;
      end
   end

   always_ff @(posedge CLK2 or negedge rst_n) begin
      if (!rst_n) begin
         save_hit <= 1'b0;
         rom_hit  <= 1'b0;
      end else begin
         save_hit <= is_save;
         rom_hit  <= is_rom;
      end
   end

   assign sram_addr = byte_addr[BYTE_AW-1:1];
   assign lane_hi   = byte_addr[0];

endmodule

// File: rtl/data_path.sv
`timescale 1ns/10ps

module data_path import cart_pkg::*; (
   input  logic               CLK2,
   input  logic               rst_n,
   input  logic [7:0]         snes_data_i,
   input  logic [7:0]         mcu_wbyte,
   input  logic [SRAM_DW-1:0] sram_dq_i,
   input  logic               lane_hi,
   input  logic               phase_mcu,
   input  logic               sram_we_n,
   input  logic               snes_latch,
   input  logic               mcu_latch,
   input  logic               snes_rd_active,
   output logic [SRAM_DW-1:0] sram_dq_o,
   output logic               sram_dq_oe,
   output logic               sram_bhe_n,
   output logic               sram_ble_n,
   output logic [7:0]         snes_data_o,
   output logic               snes_data_oe,
   output logic [7:0]         mcu_rbyte
);

   logic [7:0] wbyte_q;
   logic [7:0] rd_lane;
   logic       lane_en;
   logic       snes_valid;

   // Same write byte on both lanes with the lane strobes picking the target
   assign sram_dq_o  = {(SRAM_DW / 8){wbyte_q}};
   assign sram_dq_oe = ~sram_we_n;

   // SRAM is in use while writing, during a console read or in the MCU half
   assign lane_en    = ~sram_we_n | snes_rd_active | phase_mcu;
   assign sram_bhe_n = ~(lane_en & (sram_we_n | lane_hi));
   assign sram_ble_n = ~(lane_en & (sram_we_n | ~lane_hi));

   assign rd_lane = lane_hi ? sram_dq_i[SRAM_DW-1:8] : sram_dq_i[7:0];

   always_ff @(posedge CLK2) begin
      wbyte_q <= phase_mcu ? mcu_wbyte : snes_data_i;
      if (snes_latch) begin
         snes_data_o <= rd_lane;
      end
      if (mcu_latch) begin
         mcu_rbyte <= rd_lane;
      end
   end

   // Console bus is driven only once this read has latched its byte
   always_ff @(posedge CLK2 or negedge rst_n) begin
      if (!rst_n) begin
         snes_valid <= 1'b0;
      end else if (!snes_rd_active) begin
         snes_valid <= 1'b0;
      end else if (snes_latch) begin
         snes_valid <= 1'b1;
      end
   end

   assign snes_data_oe = snes_rd_active & snes_valid;

endmodule

// File: rtl/mcu_cmd.sv
`timescale 1ns/10ps

module mcu_cmd import cart_pkg::*, cmd_pkg::*; (
   input  logic               CLK2,
   input  logic               rst_n,
   input  logic               mcu_start,
   input  logic               mcu_valid,
   input  logic [7:0]         mcu_byte,
   input  logic               mcu_done,
   output mapper_e            mapper,
   output logic [BYTE_AW-1:0] rom_mask,
   output logic [BYTE_AW-1:0] save_mask,
   output logic [BYTE_AW-1:0] mcu_addr,
   output logic               mcu_req,
   output logic               mcu_is_write,
   output logic [7:0]         mcu_wbyte,
   output logic               mcu_rvalid
);

   cmd_op_e    op_q;
   logic [1:0] param_cnt;
   logic       param_stb;
   logic       access_stb;
   logic       shift_ok;

   assign param_stb  = mcu_valid & ~mcu_start;
   assign access_stb = param_stb & ((op_q == CMD_READ) | (op_q == CMD_WRITE));

   // Address and masks take the first three parameter bytes only
   assign shift_ok = (param_cnt != 2'd3);

   ////////////////////////////////////////////////////////////
   // Message decode

   always_ff @(posedge CLK2 or negedge rst_n) begin
      if (!rst_n) begin
         op_q         <= CMD_NOP;
         param_cnt    <= 2'd0;
         mapper       <= MAP_HIROM;
         rom_mask     <= '1;
         save_mask    <= '1;
         mcu_addr     <= '0;
         mcu_req      <= 1'b0;
         mcu_is_write <= 1'b0;
         mcu_rvalid   <= 1'b0;
      end else begin
         mcu_rvalid <= mcu_done & ~mcu_is_write;
         // Auto increment after every finished access
         if (mcu_done) begin
            mcu_req  <= 1'b0;
            mcu_addr <= mcu_addr + 1'b1;
         end
         if (mcu_valid && mcu_start) begin
            op_q      <= cmd_op_e'(mcu_byte[7:4]);
            param_cnt <= 2'd0;
         end else if (param_stb) begin
            if (shift_ok) begin
               param_cnt <= param_cnt + 2'd1;
            end
            case (op_q)
               CMD_SET_MAPPER: mapper <= mapper_e'(mcu_byte[0]);
               CMD_SET_ADDR: begin
                  if (shift_ok) begin
                     mcu_addr <= {mcu_addr[BYTE_AW-9:0], mcu_byte};
                  end
               end
               CMD_SET_ROM_MASK: begin
                  if (shift_ok) begin
                     rom_mask <= {rom_mask[BYTE_AW-9:0], mcu_byte};
                  end
               end
               CMD_SET_SAVE_MASK: begin
                  if (shift_ok) begin
                     save_mask <= {save_mask[BYTE_AW-9:0], mcu_byte};
                  end
               end
               CMD_READ, CMD_WRITE: begin
                  mcu_req      <= 1'b1;
                  mcu_is_write <= (op_q == CMD_WRITE);
               end
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge CLK2) begin
      if (access_stb && op_q == CMD_WRITE) begin
         mcu_wbyte <= mcu_byte;
      end
   end

   // The memory cycle must have served the previous byte before the next one
   assert property (@(posedge CLK2) disable iff (!rst_n) access_stb |-> !mcu_req);

endmodule

// File: rtl/cart_top.sv
`timescale 1ns/10ps

module cart_top import cart_pkg::*; #(
   parameter int HIST_DEPTH = 7
) (
   input  logic               CLK2,
   input  logic               rst_n,
   // Console bus
   input  logic [SNES_AW-1:0] snes_addr,
   input  logic               snes_rd_n,
   input  logic               snes_wr_n,
   input  logic               snes_cs_n,
   input  logic [7:0]         snes_data_i,
   output logic [7:0]         snes_data_o,
   output logic               snes_data_oe,
   // Microcontroller byte port
   input  logic               mcu_start,
   input  logic               mcu_valid,
   input  logic [7:0]         mcu_byte,
   output logic               mcu_rvalid,
   output logic [7:0]         mcu_rbyte,
   // SRAM
   output logic [SRAM_AW-1:0] sram_addr,
   output logic [SRAM_DW-1:0] sram_dq_o,
   input  logic [SRAM_DW-1:0] sram_dq_i,
   output logic               sram_dq_oe,
   output logic               sram_oe_n,
   output logic               sram_we_n,
   output logic               sram_bhe_n,
   output logic               sram_ble_n
);

   logic               rd_s;
   logic               wr_s;
   logic               cycle_start;
   logic               slot_clear;
   logic [3:0]         slot_first;
   logic               slot_run;
   logic [3:0]         slot;
   logic               slot_last;
   logic               phase_mcu;
   logic               snes_latch;
   logic               mcu_latch;
   logic               snes_rd_active;
   logic               mcu_done;
   logic               lane_hi;
   logic               save_hit;
   mapper_e            mapper;
   logic [BYTE_AW-1:0] rom_mask;
   logic [BYTE_AW-1:0] save_mask;
   logic [BYTE_AW-1:0] mcu_addr;
   logic               mcu_req;
   logic               mcu_is_write;
   logic [7:0]         mcu_wbyte;

   bus_sync #(.HIST_DEPTH(HIST_DEPTH)) i_bus_sync (.*);

   slot_timer i_slot_timer (.*);

   cycle_fsm i_cycle_fsm (.*);

   // ROM hit is kept for observation only
   addr_map i_addr_map (.*, .rom_hit());

   data_path i_data_path (.*);

   mcu_cmd i_mcu_cmd (.*);

endmodule

// File: sim/sram_model.sv
`timescale 1ns/10ps

module sram_model import cart_pkg::*; (
   input  logic [SRAM_AW-1:0] addr,
   input  logic [SRAM_DW-1:0] din,
   input  logic               din_oe,
   input  logic               oe_n,
   input  logic               we_n,
   input  logic               bhe_n,
   input  logic               ble_n,
   output logic [SRAM_DW-1:0] dout
);

   logic [SRAM_DW-1:0] mem [0:(1 << SRAM_AW) - 1];

   // Power-up content mixes every address bit into the word
   initial begin
      for (int i = 0; i < (1 << SRAM_AW); i++) begin
         mem[i] = i[15:0] ^ {i[19:16], i[19:16], i[19:16], i[19:16]};
      end
   end

   // Write is level sensitive while we_n is low
   always @(we_n or addr or din or din_oe or bhe_n or ble_n) begin
      if (!we_n && din_oe) begin
         if (!bhe_n) begin
            mem[addr][15:8] = din[15:8];
         end
         if (!ble_n) begin
            mem[addr][7:0] = din[7:0];
         end
      end
   end

   assign dout = oe_n ? '0 : mem[addr];

endmodule

// File: sim/tb_cart.sv
`timescale 1ns/10ps

module tb_cart import cart_pkg::*, cmd_pkg::*; ();

   localparam int K_CON_RD    = 0;
   localparam int K_CON_WR    = 1;
   localparam int K_SET_MAP   = 2;
   localparam int K_ROM_MASK  = 3;
   localparam int K_SAVE_MASK = 4;
   localparam int K_MCU_WR    = 5;
   localparam int K_MCU_RD    = 6;

   logic               CLK2;
   logic               rst_n;
   logic [SNES_AW-1:0] snes_addr;
   logic               snes_rd_n;
   logic               snes_wr_n;
   logic               snes_cs_n;
   logic [7:0]         snes_data_i;
   logic [7:0]         snes_data_o;
   logic               snes_data_oe;
   logic               mcu_start;
   logic               mcu_valid;
   logic [7:0]         mcu_byte;
   logic               mcu_rvalid;
   logic [7:0]         mcu_rbyte;
   logic [SRAM_AW-1:0] sram_addr;
   logic [SRAM_DW-1:0] sram_dq_o;
   logic [SRAM_DW-1:0] sram_dq_i;
   logic               sram_dq_oe;
   logic               sram_oe_n;
   logic               sram_we_n;
   logic               sram_bhe_n;
   logic               sram_ble_n;

   int                 kind_q[$];
   logic [23:0]        addr_q[$];
   logic [7:0]         data_q[$];
   logic [7:0]         ref_mem [int];
   mapper_e            cur_map;
   logic [BYTE_AW-1:0] cur_rmask;
   logic [BYTE_AW-1:0] cur_smask;
   logic [31:0]        rng;
   int                 errors;

   cart_top #(.HIST_DEPTH(7)) i_dut (.*);

   sram_model i_sram (
      .addr   (sram_addr),
      .din    (sram_dq_o),
      .din_oe (sram_dq_oe),
      .oe_n   (sram_oe_n),
      .we_n   (sram_we_n),
      .bhe_n  (sram_bhe_n),
      .ble_n  (sram_ble_n),
      .dout   (sram_dq_i)
   );

   initial begin
      CLK2 = 1'b0;
      forever #5 CLK2 = ~CLK2;
   end

   // Watchdog sized from the table
   initial begin
      #1;
      repeat (kind_q.size() * 400) @(posedge CLK2);
      $display("Timeout: the test table did not finish in time");
      $display("=== FAIL ===");
      $fatal(1, "watchdog expired");
   end

   //////////////////////////////////////////////////////////////
   // Reference model and helpers

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   function automatic logic [7:0] ref_byte(input logic [BYTE_AW-1:0] ba);
      logic [19:0] w;
      logic [15:0] fill;
      if (ref_mem.exists(int'(ba))) begin
         return ref_mem[int'(ba)];
      end
      w    = ba[20:1];
      fill = w[15:0] ^ {4{w[19:16]}};
      return ba[0] ? fill[15:8] : fill[7:0];
   endfunction

   // Maps a console address to an SRAM byte address and flags save RAM
   function automatic logic [BYTE_AW-1:0] map_addr(input logic [23:0] a, output bit is_save);
      snes_addr_u         u;
      logic [BYTE_AW-1:0] raw;
      u = a;
      if (cur_map == MAP_LOROM) begin
         is_save = !u.lo.a15 && u.lo.bank >= 8'h70 && u.lo.bank <= 8'h7D;
         if (is_save) begin
            raw = ((u.lo.bank - 8'h70) << 15) | u.lo.offs;
         end else begin
            raw = ((u.lo.bank & 8'h7F) << 15) | u.lo.offs;
         end
      end else begin
         is_save = (u.hi.bank & 8'h60) == 8'h20 && u.hi.offs >= 16'h6000 &&
                   u.hi.offs <= 16'h7FFF;
         if (is_save) begin
            raw = ((u.hi.bank & 8'h1F) << 13) | (u.hi.offs & 16'h1FFF);
         end else begin
            raw = ((u.hi.bank & 8'h3F) << 16) | u.hi.offs;
         end
      end
      if (is_save) begin
         return SAVERAM_BASE + (raw & cur_smask);
      end
      return raw & cur_rmask;
   endfunction

   task automatic report_error(input string msg);
      errors++;
      $display("FAIL %0t: %s", $time, msg);
      $display("=== FAIL ===");
      $fatal(1, "check failed");
   endtask

   task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
      if (got !== exp) begin
         report_error($sformatf("%s got %02h expected %02h", what, got, exp));
      end
   endtask

   task automatic check_mapper(input mapper_e got, input mapper_e exp);
      if (got !== exp) begin
         report_error($sformatf("mapper got %s expected %s", got.name(), exp.name()));
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         report_error($sformatf("%s got %b expected %b", what, got, exp));
      end
   endtask

   //////////////////////////////////////////////////////////////
   // Bus tasks

   task automatic send_byte(input logic start, input logic [7:0] b, output logic got,
                            output logic [7:0] rb);
      @(posedge CLK2);
      mcu_valid <= 1'b1;
      mcu_start <= start;
      mcu_byte  <= b;
      @(posedge CLK2);
      mcu_valid <= 1'b0;
      mcu_start <= 1'b0;
      got = 1'b0;
      rb  = 8'h00;
      repeat (15) begin
         @(negedge CLK2);
         if (mcu_rvalid && !got) begin
            got = 1'b1;
            rb  = mcu_rbyte;
         end
      end
   endtask

   task automatic send_long(input cmd_op_e op, input logic [23:0] v);
      logic       got;
      logic [7:0] rb;
      send_byte(1'b1, {op, 4'h0}, got, rb);
      send_byte(1'b0, v[23:16], got, rb);
      send_byte(1'b0, v[15:8], got, rb);
      send_byte(1'b0, v[7:0], got, rb);
   endtask

   task automatic mcu_write2(input logic [BYTE_AW-1:0] a, input logic [7:0] b0);
      logic       got;
      logic [7:0] rb;
      logic [7:0] b1;
      rng = xorshift(rng);
      b1  = rng[7:0];
      send_long(CMD_SET_ADDR, 24'(a));
      send_byte(1'b1, {CMD_WRITE, 4'h0}, got, rb);
      send_byte(1'b0, b0, got, rb);
      send_byte(1'b0, b1, got, rb);
      ref_mem[int'(a)]      = b0;
      ref_mem[int'(a + 1'b1)] = b1;
   endtask

   task automatic mcu_read2(input logic [BYTE_AW-1:0] a);
      logic       got;
      logic [7:0] rb;
      send_long(CMD_SET_ADDR, 24'(a));
      send_byte(1'b1, {CMD_READ, 4'h0}, got, rb);
      for (int i = 0; i < 2; i++) begin
         send_byte(1'b0, 8'h00, got, rb);
         if (!got) begin
            report_error("MCU read returned no data");
         end
         check_byte(rb, ref_byte(a + BYTE_AW'(i)), $sformatf("MCU read at %06h", a + i));
      end
   endtask

   // Holds the strobe 20 cycles, then leaves the bus idle long enough to rearm
   task automatic console_access(input logic wr, input logic [23:0] a, input logic [7:0] d);
      bit                 is_save;
      bit                 seen;
      logic [BYTE_AW-1:0] ba;
      ba   = map_addr(a, is_save);
      seen = 0;
      @(posedge CLK2);
      snes_addr   <= a;
      snes_cs_n   <= 1'b0;
      snes_data_i <= d;
      snes_rd_n   <= wr;
      snes_wr_n   <= ~wr;
      repeat (20) begin
         @(negedge CLK2);
         if (!wr && snes_data_oe && !seen) begin
            seen = 1;
            check_byte(snes_data_o, ref_byte(ba), $sformatf("console read at %06h", a));
         end
      end
      @(posedge CLK2);
      snes_rd_n <= 1'b1;
      snes_wr_n <= 1'b1;
      snes_cs_n <= 1'b1;
      repeat (12) @(posedge CLK2);
      if (!wr && !seen) begin
         report_error($sformatf("console read at %06h never drove data", a));
      end
      if (wr && is_save) begin
         ref_mem[int'(ba)] = d;
      end
   endtask

   task automatic add_step(input int k, input logic [23:0] a, input logic [7:0] d);
      kind_q.push_back(k);
      addr_q.push_back(a);
      data_q.push_back(d);
   endtask

   //////////////////////////////////////////////////////////////
   // Main sequence

   initial begin
      logic got;
      logic [7:0] rb;
      rst_n       = 1'b0;
      snes_addr   = '0;
      snes_rd_n   = 1'b1;
      snes_wr_n   = 1'b1;
      snes_cs_n   = 1'b1;
      snes_data_i = 8'h00;
      mcu_start   = 1'b0;
      mcu_valid   = 1'b0;
      mcu_byte    = 8'h00;
      cur_map     = MAP_HIROM;
      cur_rmask   = '1;
      cur_smask   = '1;
      rng         = 32'h6770_5084;
      errors      = 0;

      // HiROM MCU write and readback followed by console reads with a mask wrap
      add_step(K_MCU_WR, 24'h000100, 8'hA5);
      add_step(K_MCU_RD, 24'h000100, 8'h00);
      add_step(K_MCU_WR, 24'h012345, 8'h5A);
      add_step(K_MCU_RD, 24'h012345, 8'h00);
      add_step(K_CON_RD, 24'hC12345, 8'h00);
      add_step(K_CON_RD, 24'h400100, 8'h00);
      add_step(K_ROM_MASK, 24'h00FFFF, 8'h00);
      add_step(K_CON_RD, 24'hC10100, 8'h00);
      add_step(K_ROM_MASK, 24'h1FFFFF, 8'h00);
      // LoROM ROM, save RAM and a blocked ROM write
      add_step(K_SET_MAP, 24'h000000, 8'h01);
      add_step(K_MCU_WR, 24'h008123, 8'h3E);
      add_step(K_CON_RD, 24'h018123, 8'h00);
      add_step(K_SAVE_MASK, 24'h001FFF, 8'h00);
      add_step(K_CON_WR, 24'h700010, 8'h3C);
      add_step(K_CON_WR, 24'h702011, 8'hC3);
      add_step(K_CON_RD, 24'h700010, 8'h00);
      add_step(K_MCU_RD, 24'h1F0010, 8'h00);
      add_step(K_MCU_WR, 24'h008200, 8'h11);
      add_step(K_CON_WR, 24'h018200, 8'h77);
      add_step(K_MCU_RD, 24'h008200, 8'h00);
      // HiROM save RAM through both bank mirrors
      add_step(K_SET_MAP, 24'h000000, 8'h00);
      add_step(K_CON_WR, 24'h206005, 8'h96);
      add_step(K_CON_RD, 24'hA06005, 8'h00);
      add_step(K_MCU_RD, 24'h1F0004, 8'h00);

      repeat (4) @(posedge CLK2);
      rst_n <= 1'b1;
      @(negedge CLK2);
      check_bit(sram_we_n, 1'b1, "sram_we_n after reset");
      check_bit(sram_oe_n, 1'b1, "sram_oe_n after reset");
      check_bit(sram_dq_oe, 1'b0, "sram_dq_oe after reset");
      check_bit(sram_bhe_n, 1'b1, "sram_bhe_n after reset");
      check_bit(sram_ble_n, 1'b1, "sram_ble_n after reset");
      check_bit(snes_data_oe, 1'b0, "snes_data_oe after reset");
      check_bit(mcu_rvalid, 1'b0, "mcu_rvalid after reset");
      check_mapper(i_dut.mapper, MAP_HIROM);
      repeat (12) @(posedge CLK2);

      foreach (kind_q[i]) begin
         case (kind_q[i])
            K_CON_RD: console_access(1'b0, addr_q[i], 8'h00);
            K_CON_WR: console_access(1'b1, addr_q[i], data_q[i]);
            K_SET_MAP: begin
               send_byte(1'b1, {CMD_SET_MAPPER, 4'h0}, got, rb);
               send_byte(1'b0, data_q[i], got, rb);
               cur_map = data_q[i][0] ? MAP_LOROM : MAP_HIROM;
               check_mapper(i_dut.mapper, cur_map);
            end
            K_ROM_MASK: begin
               send_long(CMD_SET_ROM_MASK, addr_q[i]);
               cur_rmask = addr_q[i][BYTE_AW-1:0];
            end
            K_SAVE_MASK: begin
               send_long(CMD_SET_SAVE_MASK, addr_q[i]);
               cur_smask = addr_q[i][BYTE_AW-1:0];
            end
            K_MCU_WR: mcu_write2(addr_q[i][BYTE_AW-1:0], data_q[i]);
            K_MCU_RD: mcu_read2(addr_q[i][BYTE_AW-1:0]);
            default: report_error("unknown step kind in table");
         endcase
      end

      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

// File: filelist.f
rtl/cart_pkg.sv
rtl/cmd_pkg.sv
rtl/bus_sync.sv
rtl/slot_timer.sv
rtl/cycle_fsm.sv
rtl/addr_map.sv
rtl/data_path.sv
rtl/mcu_cmd.sv
rtl/cart_top.sv
sim/sram_model.sv
sim/tb_cart.sv
